//--- Bender.yml
package:
  name: spi_ctrl

sources:
  - files:
      - src/spi_pkg.sv
      - src/reg_bus_if.sv
      - src/spi_reg_file.sv
      - src/stream_fifo.sv
      - src/spi_engine.sv
      - src/spi_ctrl_top.sv
  - target: test
    files:
      - testbench/spi_ctrl_checker.sv
      - testbench/spi_ctrl_tb.sv

//--- src.f
src/spi_pkg.sv
src/reg_bus_if.sv
src/spi_reg_file.sv
src/stream_fifo.sv
src/spi_engine.sv
src/spi_ctrl_top.sv
testbench/spi_ctrl_checker.sv
testbench/spi_ctrl_tb.sv

//--- src/reg_bus_if.sv
// ##############################
// internal register access bus.
// re and we are one-cycle strobes; rvalid answers re one cycle later.
// ##############################
`timescale 1ns/100ps
`default_nettype none

interface reg_bus_if;
    import spi_pkg::*;

    logic [REG_ADDR_WIDTH-1:0] addr;
    logic [REG_DATA_WIDTH-1:0] wdata;
    logic                      we;
    logic                      re;
    logic [REG_DATA_WIDTH-1:0] rdata;
    logic                      rvalid;

    modport host (
        output addr,
        output wdata,
        output we,
        output re,
        input  rdata,
        input  rvalid
    );

    modport device (
        input  addr,
        input  wdata,
        input  we,
        input  re,
        output rdata,
        output rvalid
    );

endinterface

`default_nettype wire

//--- src/spi_ctrl_top.sv
// ##############################
// spi master controller top level.
// single clock domain; reset_i is synchronous.
// FIFO_DEPTH must be a power of two.
// ##############################
`timescale 1ns/100ps
`default_nettype none

module spi_ctrl_top #(
    parameter int FIFO_DEPTH = 16,
    parameter int SLAVE_NUM  = 2
) (
    input  logic                                clk_i,
    input  logic                                reset_i,
    input  logic [spi_pkg::REG_ADDR_WIDTH-1:0] reg_addr_i,
    input  logic [spi_pkg::REG_DATA_WIDTH-1:0] reg_wdata_i,
    input  logic                                reg_we_i,
    input  logic                                reg_re_i,
    output logic [spi_pkg::REG_DATA_WIDTH-1:0] reg_rdata_o,
    output logic                                reg_rvalid_o,
    output logic                                spi_sclk_o,
    output logic [SLAVE_NUM-1:0]                spi_cs_n_o,
    output logic                                spi_mosi_o,
    input  logic                                spi_miso_i
);
    import spi_pkg::*;

    spi_ctrl_t                       ctrl;
    logic [7:0]                      clk_div;
    logic [sel_width(SLAVE_NUM)-1:0] select;
    logic                            flush;
    logic                            busy;
    logic                            tx_push;
    tx_word_t                        tx_push_word;
    logic                            tx_push_ready;
    logic                            tx_valid;
    tx_word_t                        tx_word;
    logic                            tx_ready;
    logic                            rx_valid;
    rx_word_t                        rx_data;
    logic                            rx_ready;
    logic                            rx_pop_valid;
    rx_word_t                        rx_pop_data;
    logic                            rx_pop;

    reg_bus_if bus_if ();

    assign bus_if.addr  = reg_addr_i;
    assign bus_if.wdata = reg_wdata_i;
    assign bus_if.we    = reg_we_i;
    assign bus_if.re    = reg_re_i;
    assign reg_rdata_o  = bus_if.rdata;
    assign reg_rvalid_o = bus_if.rvalid;

    spi_reg_file #(
        .SLAVE_NUM(SLAVE_NUM)
    ) i_spi_reg_file (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .bus         (bus_if.device),
        .ctrl_o      (ctrl),
        .clk_div_o   (clk_div),
        .select_o    (select),
        .tx_valid_o  (tx_push),
        .tx_word_o   (tx_push_word),
        .tx_ready_i  (tx_push_ready),
        .tx_pending_i(tx_valid),
        .rx_valid_i  (rx_pop_valid),
        .rx_data_i   (rx_pop_data),
        .rx_space_i  (rx_ready),
        .rx_pop_o    (rx_pop),
        .busy_i      (busy),
        .flush_o     (flush)
    );

    stream_fifo #(
        .DEPTH    (FIFO_DEPTH),
        .payload_t(tx_word_t)
    ) i_tx_fifo (
        .clk_i    (clk_i),
        .reset_i  (reset_i),
        .flush_i  (flush),
        .s_valid_i(tx_push),
        .s_data_i (tx_push_word),
        .s_ready_o(tx_push_ready),
        .m_valid_o(tx_valid),
        .m_data_o (tx_word),
        .m_ready_i(tx_ready)
    );

    stream_fifo #(
        .DEPTH    (FIFO_DEPTH),
        .payload_t(rx_word_t)
    ) i_rx_fifo (
        .clk_i    (clk_i),
        .reset_i  (reset_i),
        .flush_i  (flush),
        .s_valid_i(rx_valid),
        .s_data_i (rx_data),
        .s_ready_o(rx_ready),
        .m_valid_o(rx_pop_valid),
        .m_data_o (rx_pop_data),
        .m_ready_i(rx_pop)
    );

    spi_engine #(
        .SLAVE_NUM(SLAVE_NUM)
    ) i_spi_engine (
        .clk_i     (clk_i),
        .reset_i   (reset_i),
        .flush_i   (flush),
        .ctrl_i    (ctrl),
        .clk_div_i (clk_div),
        .select_i  (select),
        .tx_valid_i(tx_valid),
        .tx_word_i (tx_word),
        .tx_ready_o(tx_ready),
        .rx_valid_o(rx_valid),
        .rx_data_o (rx_data),
        .rx_ready_i(rx_ready),
        .busy_o    (busy),
        .sclk_o    (spi_sclk_o),
        .cs_n_o    (spi_cs_n_o),
        .mosi_o    (spi_mosi_o),
        .miso_i    (spi_miso_i)
    );

endmodule

`default_nettype wire

//--- src/spi_engine.sv
// ##############################
// spi shift engine, msb first, all four cpol/cpha modes.
// half period is clk_div_i+1 clock cycles.
// the slave index is latched when chip select falls.
// a full rx fifo stalls the engine in hold.
// ##############################
`timescale 1ns/100ps
`default_nettype none

module spi_engine #(
    parameter int SLAVE_NUM = 2
) (
    input  logic                                     clk_i,
    input  logic                                     reset_i,
    input  logic                                     flush_i,
    input  spi_pkg::spi_ctrl_t                       ctrl_i,
    input  logic [7:0]                               clk_div_i,
    input  logic [spi_pkg::sel_width(SLAVE_NUM)-1:0] select_i,
    input  logic                                     tx_valid_i,
    input  spi_pkg::tx_word_t                        tx_word_i,
    output logic                                     tx_ready_o,
    output logic                                     rx_valid_o,
    output spi_pkg::rx_word_t                        rx_data_o,
    input  logic                                     rx_ready_i,
    output logic                                     busy_o,
    output logic                                     sclk_o,
    output logic [SLAVE_NUM-1:0]                     cs_n_o,
    output logic                                     mosi_o,
    input  logic                                     miso_i
);
    import spi_pkg::*;

    localparam int EDGE_WIDTH = $clog2(2 * DATA_WIDTH);
    localparam logic [EDGE_WIDTH-1:0] EDGE_LAST = EDGE_WIDTH'(2 * DATA_WIDTH - 1);

    typedef enum logic [2:0] {IDLE, SELECT, SHIFT, HOLD, RELEASE} state_t;

    state_t                          state_q;
    logic [7:0]                      div_cnt_q;
    logic [EDGE_WIDTH-1:0]           edge_cnt_q;
    logic                            phase_q;
    logic                            cs_active_q;
    logic [sel_width(SLAVE_NUM)-1:0] sel_q;
    logic                            mosi_q;
    logic                            last_q;
    logic [DATA_WIDTH-1:0]           tx_sh_q;
    logic [DATA_WIDTH-1:0]           rx_sh_q;
    logic                            tick;
    logic                            tx_take;
    logic                            shift_tick;
    logic                            drive_edge;

    assign tick       = (div_cnt_q >= clk_div_i);
    assign tx_take    = tx_valid_i && tx_ready_o;
    assign shift_tick = (state_q == SHIFT) && tick;
    assign drive_edge = edge_cnt_q[0] ^ ctrl_i.cpha; // even edges lead.

    always_ff @(posedge clk_i) begin
        if (reset_i || flush_i) begin
            state_q     <= IDLE;
            div_cnt_q   <= '0;
            edge_cnt_q  <= '0;
            phase_q     <= 1'b0;
            cs_active_q <= 1'b0;
            sel_q       <= '0;
            mosi_q      <= 1'b0;
        end else begin
            case (state_q)
                IDLE: begin
                    div_cnt_q <= '0;
                    if (tx_take) begin
                        state_q     <= SELECT;
                        cs_active_q <= 1'b1;
                        mosi_q      <= tx_word_i.data[DATA_WIDTH-1];
                        if (!cs_active_q) sel_q <= select_i;
                    end
                end
                SELECT: begin
                    div_cnt_q  <= tick ? '0 : div_cnt_q + 8'd1;
                    edge_cnt_q <= '0;
                    if (tick) state_q <= SHIFT;
                end
                SHIFT: begin
                    div_cnt_q <= tick ? '0 : div_cnt_q + 8'd1;
                    if (tick) begin
                        phase_q    <= ~phase_q;
                        edge_cnt_q <= edge_cnt_q + 1'b1;
                        if (drive_edge) mosi_q <= tx_sh_q[DATA_WIDTH-1];
                        if (edge_cnt_q == EDGE_LAST) state_q <= HOLD;
                    end
                end
                HOLD: begin
                    if (!tick) div_cnt_q <= div_cnt_q + 8'd1; // keeps timing the release.
                    if (rx_ready_i) state_q <= last_q ? RELEASE : IDLE;
                end
                RELEASE: begin
                    if (!tick) div_cnt_q <= div_cnt_q + 8'd1;
                    if (tick) begin
                        cs_active_q <= 1'b0;
                        state_q     <= IDLE;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    // ############################## shift registers
    always_ff @(posedge clk_i) begin
        if (tx_take) begin
            tx_sh_q <= ctrl_i.cpha ? tx_word_i.data : tx_word_i.data << 1;
            last_q  <= tx_word_i.last;
        end else if (shift_tick) begin
            if (drive_edge) tx_sh_q <= tx_sh_q << 1;
            else            rx_sh_q <= {rx_sh_q[DATA_WIDTH-2:0], miso_i};
        end
    end

    assign tx_ready_o = (state_q == IDLE);
    assign rx_valid_o = (state_q == HOLD);
    assign rx_data_o  = rx_sh_q;
    assign busy_o     = (state_q != IDLE) || cs_active_q;
    assign sclk_o     = phase_q ^ ctrl_i.cpol; // idles at cpol.
    assign cs_n_o     = ~(SLAVE_NUM'(cs_active_q) << sel_q);
    assign mosi_o     = mosi_q;

endmodule

`default_nettype wire

//--- src/spi_pkg.sv
// ##############################
// shared types and register map for the spi master.
// one spi word is DATA_WIDTH bits, shifted msb first.
// ##############################
`default_nettype none

package spi_pkg;

    localparam int DATA_WIDTH     = 8;
    localparam int REG_ADDR_WIDTH = 3;
    localparam int REG_DATA_WIDTH = 16;

    // ############################## register map
    localparam logic [REG_ADDR_WIDTH-1:0] CTRL_ADDR    = 3'd0;
    localparam logic [REG_ADDR_WIDTH-1:0] CLK_DIV_ADDR = 3'd1;
    localparam logic [REG_ADDR_WIDTH-1:0] SELECT_ADDR  = 3'd2;
    localparam logic [REG_ADDR_WIDTH-1:0] TX_DATA_ADDR = 3'd3; // write only.
    localparam logic [REG_ADDR_WIDTH-1:0] RX_DATA_ADDR = 3'd4; // read pops rx fifo.
    localparam logic [REG_ADDR_WIDTH-1:0] STATUS_ADDR  = 3'd5;

    typedef struct packed {
        logic soft_reset; // bit 2, self clearing.
        logic cpha;       // bit 1.
        logic cpol;       // bit 0.
    } spi_ctrl_t;

    typedef struct packed {
        logic                  last; // release chip select after this word.
        logic [DATA_WIDTH-1:0] data;
    } tx_word_t;

    typedef logic [DATA_WIDTH-1:0] rx_word_t;

    typedef struct packed {
        logic busy;
        logic rx_full;
        logic rx_empty;
        logic tx_full;
        logic tx_empty; // bit 0.
    } spi_status_t;

    // width of a slave index, never below one bit
    function automatic int sel_width(input int slave_num);
        return (slave_num > 1) ? $clog2(slave_num) : 1;
    endfunction

endpackage

`default_nettype wire

//--- src/spi_reg_file.sv
// ##############################
// register decode for the spi master.
// tx pushes while the tx fifo is full are dropped.
// reading an empty rx fifo returns zero.
// ##############################
`timescale 1ns/100ps
`default_nettype none

module spi_reg_file #(
    parameter int SLAVE_NUM = 2
) (
    input  logic                                        clk_i,
    input  logic                                        reset_i,
    reg_bus_if.device                                   bus,
    output spi_pkg::spi_ctrl_t                          ctrl_o,
    output logic [7:0]                                  clk_div_o,
    output logic [spi_pkg::sel_width(SLAVE_NUM)-1:0]    select_o,
    output logic                                        tx_valid_o,
    output spi_pkg::tx_word_t                           tx_word_o,
    input  logic                                        tx_ready_i,
    input  logic                                        tx_pending_i,
    input  logic                                        rx_valid_i,
    input  spi_pkg::rx_word_t                           rx_data_i,
    input  logic                                        rx_space_i,
    output logic                                        rx_pop_o,
    input  logic                                        busy_i,
    output logic                                        flush_o
);
    import spi_pkg::*;

    localparam int SEL_WIDTH = sel_width(SLAVE_NUM);

    spi_ctrl_t                 ctrl_q;
    logic [7:0]                clk_div_q;
    logic [SEL_WIDTH-1:0]      select_q;
    logic                      rvalid_q;
    logic [REG_DATA_WIDTH-1:0] rdata_q;
    logic [REG_DATA_WIDTH-1:0] rdata_d;
    spi_status_t               status;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            ctrl_q    <= '0;
            clk_div_q <= '0;
            select_q  <= '0;
            rvalid_q  <= 1'b0;
        end else begin
            ctrl_q.soft_reset <= 1'b0; // one cycle pulse.
            rvalid_q          <= bus.re;
            if (bus.we) begin
                case (bus.addr)
                    CTRL_ADDR:    ctrl_q    <= spi_ctrl_t'(bus.wdata[$bits(spi_ctrl_t)-1:0]);
                    CLK_DIV_ADDR: clk_div_q <= bus.wdata[7:0];
                    SELECT_ADDR:  select_q  <= bus.wdata[SEL_WIDTH-1:0];
                    default:      ;
                endcase
            end
        end
    end

    // ############################## fifo strobes
    assign tx_valid_o = bus.we && (bus.addr == TX_DATA_ADDR);
    assign tx_word_o  = tx_word_t'(bus.wdata[$bits(tx_word_t)-1:0]);
    assign rx_pop_o   = bus.re && (bus.addr == RX_DATA_ADDR) && rx_valid_i;

    always_comb begin
        status.tx_empty = ~tx_pending_i;
        status.tx_full  = ~tx_ready_i;
        status.rx_empty = ~rx_valid_i;
        status.rx_full  = ~rx_space_i;
        status.busy     = busy_i;
    end

    always_comb begin
        case (bus.addr)
            CTRL_ADDR:    rdata_d = REG_DATA_WIDTH'(ctrl_q);
            CLK_DIV_ADDR: rdata_d = REG_DATA_WIDTH'(clk_div_q);
            SELECT_ADDR:  rdata_d = REG_DATA_WIDTH'(select_q);
            RX_DATA_ADDR: rdata_d = rx_valid_i ? REG_DATA_WIDTH'(rx_data_i) : '0;
            STATUS_ADDR:  rdata_d = REG_DATA_WIDTH'(status);
            default:      rdata_d = '0;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (bus.re) begin
            rdata_q <= rdata_d;
        end
    end

    assign bus.rdata  = rdata_q;
    assign bus.rvalid = rvalid_q;
    assign ctrl_o     = ctrl_q;
    assign clk_div_o  = clk_div_q;
    assign select_o   = select_q;
    assign flush_o    = ctrl_q.soft_reset;

endmodule

`default_nettype wire

//--- src/stream_fifo.sv
// ##############################
// synchronous valid/ready fifo, first word fall through.
// DEPTH must be a power of two, at least 2.
// flush empties the fifo in one cycle.
// ##############################
`timescale 1ns/100ps
`default_nettype none

module stream_fifo #(
    parameter int  DEPTH     = 16,
    parameter type payload_t = logic [7:0]
) (
    input  logic     clk_i,
    input  logic     reset_i,
    input  logic     flush_i,
    input  logic     s_valid_i,
    input  payload_t s_data_i,
    output logic     s_ready_o,
    output logic     m_valid_o,
    output payload_t m_data_o,
    input  logic     m_ready_i
);

    localparam int PTR_WIDTH = $clog2(DEPTH);

    payload_t               mem_q [DEPTH];
    logic [PTR_WIDTH-1:0]   wr_ptr_q;
    logic [PTR_WIDTH-1:0]   rd_ptr_q;
    logic [PTR_WIDTH:0]     count_q;
    logic                   push;
    logic                   pop;

    assign s_ready_o = (count_q != (PTR_WIDTH+1)'(DEPTH));
    assign m_valid_o = (count_q != '0);
    assign m_data_o  = mem_q[rd_ptr_q];

    assign push = s_valid_i && s_ready_o;
    assign pop  = m_valid_o && m_ready_i;

    always_ff @(posedge clk_i) begin
        if (reset_i || flush_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) wr_ptr_q <= wr_ptr_q + 1'b1; // wraps at DEPTH.
            if (pop)  rd_ptr_q <= rd_ptr_q + 1'b1;
            case ({push, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) begin
            mem_q[wr_ptr_q] <= s_data_i;
        end
    end

endmodule

`default_nettype wire

//--- testbench/spi_ctrl_checker.sv
// ##############################
// spi protocol assertions, bound into spi_ctrl_top.
// cpol is taken from the control register inside the top.
// fail_count is read by the testbench at the end of the run.
// ##############################
`timescale 1ns/100ps
`default_nettype none

module spi_ctrl_checker #(
    parameter int SLAVE_NUM = 2
) (
    input logic                 clk_i,
    input logic                 reset_i,
    input logic                 re_i,
    input logic                 rvalid_i,
    input logic                 sclk_i,
    input logic [SLAVE_NUM-1:0] cs_n_i,
    input logic                 cpol_i
);

    int fail_count = 0;

    cs_single: assert property (@(posedge clk_i) disable iff (reset_i)
        $countones(~cs_n_i) <= 1)
        else begin
            fail_count++;
            $error("more than one chip select low: %b", cs_n_i);
        end

    // the clock only leaves its idle level inside a frame.
    sclk_idle: assert property (@(posedge clk_i) disable iff (reset_i)
        (&cs_n_i) |-> (sclk_i == cpol_i))
        else begin
            fail_count++;
            $error("sclk %b differs from cpol %b while deselected", sclk_i, cpol_i);
        end

    rvalid_follows_re: assert property (@(posedge clk_i) disable iff (reset_i)
        rvalid_i == $past(re_i))
        else begin
            fail_count++;
            $error("rvalid does not follow re by one cycle");
        end

endmodule

bind spi_ctrl_top spi_ctrl_checker #(
    .SLAVE_NUM(SLAVE_NUM)
) checker_i (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .re_i    (reg_re_i),
    .rvalid_i(reg_rvalid_o),
    .sclk_i  (spi_sclk_o),
    .cs_n_i  (spi_cs_n_o),
    .cpol_i  (ctrl.cpol)
);

`default_nettype wire

//--- testbench/spi_ctrl_tb.sv
// ##############################
// testbench for spi_ctrl_top with FIFO_DEPTH 4 and SLAVE_NUM 2.
// miso is looped back from mosi, so each byte returns unchanged.
// data bytes come from a 16 bit galois lfsr.
// relies on the bound spi_ctrl_checker for its assertion count.
// ##############################
`timescale 1ns/100ps
`default_nettype none

module spi_ctrl_tb;
    import spi_pkg::*;

    localparam int CLK_PERIOD  = 20;
    localparam int MAX_DIV     = 3;
    localparam int NUM_BYTES   = 49;                        // all exchanges together.
    localparam int BYTE_CYCLES = 18 * (MAX_DIV + 1) + 60;   // worst byte plus polling.
    localparam int WATCHDOG_NS = (NUM_BYTES * BYTE_CYCLES + 2000) * CLK_PERIOD;
    localparam int POLL_LIMIT  = 500;
    localparam int ST_RX_EMPTY = 2;
    localparam int ST_TX_FULL  = 1;
    localparam int ST_RX_FULL  = 3;
    localparam int ST_BUSY     = 4;

    logic                      clk;
    logic                      reset;
    logic [REG_ADDR_WIDTH-1:0] reg_addr;
    logic [REG_DATA_WIDTH-1:0] reg_wdata;
    logic                      reg_we;
    logic                      reg_re;
    logic [REG_DATA_WIDTH-1:0] reg_rdata;
    logic                      reg_rvalid;
    logic                      spi_sclk;
    logic [1:0]                spi_cs_n;
    logic                      spi_mosi;
    logic                      spi_miso;

    logic [15:0] lfsr_state;
    logic [7:0]  sent_q [$];
    logic [7:0]  got_q [$];
    int          errors;
    int          bytes_checked;
    int          half_period;
    logic        cur_cpol;
    logic        sclk_prev;
    logic [1:0]  cs_prev;
    int          since_toggle;
    int          toggles;
    int          cs_falls [2];

    spi_ctrl_top #(
        .FIFO_DEPTH(4),
        .SLAVE_NUM (2)
    ) dut_i (
        .clk_i       (clk),
        .reset_i     (reset),
        .reg_addr_i  (reg_addr),
        .reg_wdata_i (reg_wdata),
        .reg_we_i    (reg_we),
        .reg_re_i    (reg_re),
        .reg_rdata_o (reg_rdata),
        .reg_rvalid_o(reg_rvalid),
        .spi_sclk_o  (spi_sclk),
        .spi_cs_n_o  (spi_cs_n),
        .spi_mosi_o  (spi_mosi),
        .spi_miso_i  (spi_miso)
    );

    assign spi_miso = spi_mosi; // loopback.

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // galois lfsr, x^16 + x^14 + x^13 + x^11 + 1.
    function automatic logic [15:0] lfsr_step(input logic [15:0] state);
        return {1'b0, state[15:1]} ^ (state[0] ? 16'hB400 : 16'h0000);
    endfunction

    // mosi feeds miso, so the received byte is the sent byte.
    function automatic logic [7:0] loopback_byte(input logic [7:0] sent);
        return sent;
    endfunction

    task automatic check_value(input string name, input logic [15:0] expected,
                               input logic [15:0] actual);
        assert (actual == expected) else begin
            errors++;
            $display("[ERROR] %0t %s: expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    task automatic draw_byte(output logic [7:0] data);
        data = '0;
        for (int i = 0; i < 8; i++) begin
            data       = {data[6:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);
        end
    endtask

    // ############################## register bus
    task automatic write_reg(input logic [REG_ADDR_WIDTH-1:0] addr, input logic [15:0] data);
        @(posedge clk);
        reg_addr  <= addr;
        reg_wdata <= data;
        reg_we    <= 1'b1;
        @(posedge clk);
        reg_we    <= 1'b0;
    endtask

    task automatic read_reg(input logic [REG_ADDR_WIDTH-1:0] addr, output logic [15:0] data);
        int waited;
        waited = 0;
        data   = '0;
        @(posedge clk);
        reg_addr <= addr;
        reg_re   <= 1'b1;
        @(posedge clk);
        reg_re   <= 1'b0;
        do begin
            @(posedge clk);
            waited++;
        end while (!reg_rvalid && waited < 4);
        assert (reg_rvalid) else begin
            errors++;
            $display("%0t: no rvalid after a read of address %0d", $time, addr);
        end
        data = reg_rdata;
    endtask

    task automatic wait_status(input int idx, input logic value, input string what);
        logic [15:0] data;
        int          polls;
        polls = 0;
        read_reg(STATUS_ADDR, data);
        while (data[idx] != value && polls < POLL_LIMIT) begin
            read_reg(STATUS_ADDR, data);
            polls++;
        end
        assert (data[idx] == value) else begin
            errors++;
            $display("%0t: timed out waiting for %s", $time, what);
        end
    endtask

    task automatic configure(input logic cpol, input logic cpha, input int div, input int sel);
        write_reg(CTRL_ADDR, {13'd0, 1'b0, cpha, cpol});
        write_reg(CLK_DIV_ADDR, 16'(div));
        write_reg(SELECT_ADDR, 16'(sel));
        half_period = div + 1;
        cur_cpol    = cpol;
    endtask

    task automatic send_burst(input int count);
        logic [7:0] data;
        for (int i = 0; i < count; i++) begin
            draw_byte(data);
            wait_status(ST_TX_FULL, 1'b0, "tx fifo space");
            write_reg(TX_DATA_ADDR, {7'd0, (i == count - 1), data}); // last on final byte.
            sent_q.push_back(data);
        end
    endtask

    task automatic recv_burst(input int count);
        logic [15:0] data;
        for (int i = 0; i < count; i++) begin
            wait_status(ST_RX_EMPTY, 1'b0, "rx data");
            read_reg(RX_DATA_ADDR, data);
            got_q.push_back(data[7:0]);
        end
        wait_status(ST_BUSY, 1'b0, "engine idle");
        check_value("spi_cs_n_o", 2'b11, spi_cs_n);
        check_value("spi_sclk_o", cur_cpol, spi_sclk);
    endtask

    // ############################## monitors
    always @(posedge clk) begin
        if (got_q.size() > 0) begin
            bytes_checked++;
            assert (sent_q.size() > 0) else begin
                errors++;
                $display("%0t: a byte came back that was never sent", $time);
            end
            if (sent_q.size() == 0) begin
                got_q.delete();
            end else begin
                check_value("reg_rdata_o", loopback_byte(sent_q.pop_front()), got_q.pop_front());
            end
        end
    end

    always @(posedge clk) begin
        if (reset) begin
            sclk_prev    <= 1'b0;
            cs_prev      <= 2'b11;
            since_toggle <= 0;
            toggles      <= 0;
            for (int i = 0; i < 2; i++) cs_falls[i] <= 0;
        end else begin
            since_toggle <= since_toggle + 1;
            if (spi_sclk != sclk_prev && !(&spi_cs_n)) begin
                if (toggles % 16 != 0) begin // first edge of a byte follows select.
                    check_value("spi_sclk_o half period", half_period, since_toggle);
                end
                toggles      <= toggles + 1;
                since_toggle <= 1;
            end
            for (int i = 0; i < 2; i++) begin
                if (cs_prev[i] && !spi_cs_n[i]) cs_falls[i] <= cs_falls[i] + 1;
            end
            sclk_prev <= spi_sclk;
            cs_prev   <= spi_cs_n;
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("%0t: watchdog expired before the test sequence finished", $time);
        $display("Simulation FAILED");
        $finish;
    end

    // ############################## test sequence
    initial begin
        logic [15:0] data;
        int          toggles_start;
        int          falls_start [2];
        int          assert_fails;
        reset         = 1'b1;
        reg_addr      = '0;
        reg_wdata     = '0;
        reg_we        = 1'b0;
        reg_re        = 1'b0;
        errors        = 0;
        bytes_checked = 0;
        half_period   = 1;
        cur_cpol      = 1'b0;
        lfsr_state    = 16'd48894;
        repeat (8) @(posedge clk);
        reset <= 1'b0;

        read_reg(STATUS_ADDR, data);
        check_value("status", 16'h0005, data); // tx_empty and rx_empty only.
        check_value("spi_cs_n_o", 2'b11, spi_cs_n);
        check_value("spi_sclk_o", 1'b0, spi_sclk);

        for (int mode = 0; mode < 4; mode++) begin
            configure(mode[1], mode[0], 1, 0);
            send_burst(8);
            recv_burst(8);
        end

        configure(1'b0, 1'b0, 3, 0);
        toggles_start = toggles;
        send_burst(8);
        recv_burst(8);
        check_value("spi_sclk_o toggle count", 16 * 8, toggles - toggles_start);

        configure(1'b0, 1'b0, 1, 1);
        falls_start[0] = cs_falls[0];
        falls_start[1] = cs_falls[1];
        send_burst(3);
        recv_burst(3);
        check_value("spi_cs_n_o[0] falls", 0, cs_falls[0] - falls_start[0]);
        check_value("spi_cs_n_o[1] falls", 1, cs_falls[1] - falls_start[1]);

        // rx fifo back-pressure, the fifth byte waits in the engine.
        configure(1'b0, 1'b0, 1, 0);
        send_burst(6);
        wait_status(ST_RX_FULL, 1'b1, "rx fifo full");
        repeat (4 * BYTE_CYCLES) @(posedge clk);
        read_reg(STATUS_ADDR, data);
        check_value("status", 16'h0018, data);
        recv_burst(6);

        repeat (2) @(posedge clk);
        assert (sent_q.size() == 0) else begin
            errors++;
            $display("%0t: %0d sent bytes never came back", $time, sent_q.size());
        end
        assert_fails = dut_i.checker_i.fail_count;
        $display("%0d bytes compared, %0d errors, %0d assertion failures",
                 bytes_checked, errors, assert_fails);
        if (errors == 0 && assert_fails == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
